// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_kiwi_ctrl_core
FILELIST  = kiwi_ctrl_core.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Simulation completed successfully
FAIL_MSG  = Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test: FAIL, run ended early"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: kiwi_ctrl_core.f
source/kiwi_pkg.sv
source/cpu_bus_if.sv
source/ctrl_regs.sv
source/chip_id_reader.sv
source/cycle_counters.sv
source/cpu_readback.sv
source/kiwi_ctrl_core.sv
verification/kiwi_ctrl_core_assert.sv
verification/tb_kiwi_ctrl_core.sv

// File: source/chip_id_reader.sv
`timescale 1ns/100ps

module chip_id_reader #(
    parameter logic [kiwi_pkg::ID_BITS-1:0] CHIP_ID = '1
) (
    input  logic cpu_clk,
    input  logic rx_orst,
    input  logic id_read,       // latch level, qualified below
    input  logic id_clk,
    input  logic id_shift,
    output logic id_bit         // msb first
);
    import kiwi_pkg::*;

    localparam int CNT_BITS = $clog2(ID_BITS + 1);
    localparam logic [1:0] RISE = 2'b01;

    typedef enum logic [1:0] {
        ID_IDLE,        // nothing loaded yet
        ID_LOADED,      // bits still to come out
        ID_DRAINED      // all bits shifted out
    } id_state_e;

    id_state_e            id_state;
    logic [1:0]           rd_hist;      // read & clk history
    logic [1:0]           sf_hist;      // shift & clk history
    logic                 rd_pulse;
    logic                 sf_pulse;
    logic [ID_BITS-1:0]   id_sr;
    logic [CNT_BITS-1:0]  shift_cnt;

    ////////////////////////////////////////
    // level to single pulse
    ////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            rd_hist <= 2'b00;
            sf_hist <= 2'b00;
        end
        else
        begin
            rd_hist <= {rd_hist[0], id_read && id_clk};
            sf_hist <= {sf_hist[0], id_shift && id_clk};
        end
    end

    assign rd_pulse = (rd_hist == RISE);
    assign sf_pulse = (sf_hist == RISE);

    ////////////////////////////////////////
    // load / shift fsm
    ////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            id_state  <= ID_IDLE;
            shift_cnt <= '0;
        end
        else if (rd_pulse)      // read wins over shift
        begin
            id_state  <= ID_LOADED;
            shift_cnt <= '0;
        end
        else if (sf_pulse && id_state == ID_LOADED)
        begin
            shift_cnt <= shift_cnt + 1'b1;
            if (shift_cnt == CNT_BITS'(ID_BITS - 1))
                id_state <= ID_DRAINED;     // last bit gone
        end
    end

    // shift register, ones fill from the bottom
    always_ff @(posedge cpu_clk)
    begin
        if (rd_pulse)
            id_sr <= CHIP_ID;
        else if (sf_pulse)
            id_sr <= {id_sr[ID_BITS-2:0], 1'b1};
    end

    // idle and drained read as one
    assign id_bit = (id_state == ID_LOADED) ? id_sr[ID_BITS-1] : 1'b1;

endmodule

// File: source/cpu_bus_if.sv
`timescale 1ns/100ps

// cpu register / event strobes, all single cycle, no ack
interface cpu_bus_if;
    import kiwi_pkg::*;

    cpu_op_e                op;         // valid with any strobe
    logic [REG_NO_BITS-1:0] reg_no;     // readback register select
    logic [TOS_BITS-1:0]    tos;        // operand for writes
    logic                   rd_reg;     // parallel input read
    logic                   wr_reg;     // register write
    logic                   wr_evt;     // event strobe

    // control register block
    modport ctrl_sink (
        input op,
        input tos,
        input wr_reg
    );

    // cycle counter events
    modport evt_sink (
        input op,
        input wr_evt
    );

    // readback mux and srq capture
    modport rd_sink (
        input op,
        input reg_no,
        input rd_reg
    );

endinterface

// File: source/cpu_readback.sv
`timescale 1ns/100ps

module cpu_readback #(
    parameter logic [2:0] FPGA_ID = 3'd0
) (
    input  logic                          cpu_clk,
    input  logic                          rx_orst,
    cpu_bus_if.rd_sink                    bus,
    input  logic                          host_srq,
    input  logic                          rx_ovfl,
    input  logic                          id_bit,
    input  logic [kiwi_pkg::CTR_BITS-1:0] ctr0,
    input  logic [kiwi_pkg::CTR_BITS-1:0] ctr1,
    output logic [kiwi_pkg::PAR_BITS-1:0] par,
    output logic                          ser_srq
);
    import kiwi_pkg::*;

    logic                rx_overflow;   // sticky
    logic                srq_noted;
    logic                get_status;
    logic                get_ctr;
    logic                get_srq;
    logic [PAR_BITS-1:0] status;
    logic [4:0]          byte_lsb;      // bit offset of selected byte

    assign get_status = bus.rd_reg && bus.op == OP_GET_STATUS;
    assign get_ctr    = bus.rd_reg && bus.op == OP_GET_CPU_CTR;
    assign get_srq    = bus.rd_reg && bus.op == OP_GET_SRQ;

    ////////////////////////////////////////
    // overflow and srq capture
    ////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            rx_overflow <= 1'b0;
        else
            rx_overflow <= rx_overflow | rx_ovfl;   // only reset clears
    end

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            srq_noted <= 1'b0;
            ser_srq   <= 1'b0;
        end
        else if (get_srq)
        begin
            ser_srq   <= srq_noted;     // hand to cpu
            srq_noted <= host_srq;      // restart note
        end
        else
            srq_noted <= srq_noted | host_srq;
    end

    ////////////////////////////////////////
    // parallel input mux
    ////////////////////////////////////////

    // ovfl, id bit, fpga id, zero pad
    assign status   = {rx_overflow, id_bit, FPGA_ID, {(PAR_BITS-5){1'b0}}};
    assign byte_lsb = {bus.reg_no, 3'b000};

    always_comb
    begin
        if (get_status && bus.reg_no == '0)
            par = status;
        else if (get_ctr)
            par = {ctr1[byte_lsb +: 8], ctr0[byte_lsb +: 8]};  // interleaved bytes
        else
            par = '0;
    end

endmodule

// File: source/ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs (
    input  logic         cpu_clk,
    input  logic         rx_orst,
    cpu_bus_if.ctrl_sink bus,

    // chip id reader, internal
    output logic         id_read,
    output logic         id_clk,
    output logic         id_shift,

    // attenuator dac
    output logic         da_dale,
    output logic         da_daclk,
    output logic         da_dadat,

    // gps front end
    output logic         gps_gscs,
    output logic         gps_gsclk,
    output logic         gps_gsdat,

    // board pins
    output logic         adc_clken,
    output logic         adc_stenl,
    output logic         ewp,
    output logic         cmd_ready,
    output logic         snd_intr
);
    import kiwi_pkg::*;

    logic [CTRL_BITS-1:0] ctrl;
    ser_sel_e             ser_sel;
    logic [2:0]           ser_pins;     // {le_csn, clk, data}

    // only the selected port sees the serial bits
    function automatic logic [2:0] gate_port(input ser_sel_e sel,
                                             input ser_sel_e port,
                                             input logic [2:0] pins);
        return (sel == port) ? pins : 3'b000;
    endfunction

    ////////////////////////////////////////
    // control register
    ////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctrl <= '0;
        else if (bus.wr_reg && bus.op == OP_SET_CTRL)
            ctrl <= bus.tos[CTRL_BITS-1:0];     // upper operand bits ignored
    end

    ////////////////////////////////////////
    // serial port steering
    ////////////////////////////////////////

    assign ser_sel  = ser_sel_e'(ctrl[CTRL_SER_SEL +: SER_SEL_BITS]);
    assign ser_pins = {ctrl[CTRL_SER_LE_CSN], ctrl[CTRL_SER_CLK], ctrl[CTRL_SER_DATA]};

    assign {da_dale, da_daclk, da_dadat}    = gate_port(ser_sel, SER_ATTN, ser_pins);
    assign {gps_gscs, gps_gsclk, gps_gsdat} = gate_port(ser_sel, SER_GPS, ser_pins);
    assign {id_read, id_clk, id_shift}      = gate_port(ser_sel, SER_ID, ser_pins);

    // board control, active low pins inverted here
    assign adc_clken = !ctrl[CTRL_OSC_DIS];
    assign adc_stenl = !ctrl[CTRL_STEN];
    assign ewp       = ctrl[CTRL_EEPROM_WP];
    assign cmd_ready = ctrl[CTRL_CMD_READY];
    assign snd_intr  = ctrl[CTRL_SND_INTR];

endmodule

// File: source/cycle_counters.sv
`timescale 1ns/100ps

module cycle_counters (
    input  logic                          cpu_clk,
    input  logic                          rx_orst,
    cpu_bus_if.evt_sink                   bus,
    output logic [kiwi_pkg::CTR_BITS-1:0] ctr0,     // free running
    output logic [kiwi_pkg::CTR_BITS-1:0] ctr1      // gated by enable
);
    import kiwi_pkg::*;

    logic                ctr_ena;
    logic                ctr_clr;
    logic [1:0]          ctr_inc;       // per-counter increment
    logic [CTR_BITS-1:0] ctr [2];

    assign ctr_clr = bus.wr_evt && bus.op == OP_CTR_CLR;
    assign ctr_inc = {ctr_ena, 1'b1};   // ctr1 on enable, ctr0 always

    ////////////////////////////////////////
    // enable flag
    ////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctr_ena <= 1'b0;
        else if (bus.wr_evt && bus.op == OP_CTR_ENA)
            ctr_ena <= 1'b1;
        else if (bus.wr_evt && bus.op == OP_CTR_DIS)
            ctr_ena <= 1'b0;
    end

    ////////////////////////////////////////
    // accumulators
    ////////////////////////////////////////

    for (genvar i = 0; i < 2; i++)
    begin : g_ctr
        always_ff @(posedge cpu_clk)
        begin
            if (rx_orst || ctr_clr)
                ctr[i] <= '0;
            else
                ctr[i] <= ctr[i] + CTR_BITS'(ctr_inc[i]);   // wraps at 2^32
        end
    end

    assign ctr0 = ctr[0];
    assign ctr1 = ctr[1];

endmodule

// File: source/kiwi_ctrl_core.sv
`timescale 1ns/100ps

module kiwi_ctrl_core #(
    parameter logic [kiwi_pkg::ID_BITS-1:0] CHIP_ID = 57'h1_a5c3_e97b_0d24_68,
    parameter logic [2:0]                   FPGA_ID = 3'd1
) (
    input  logic                             cpu_clk,
    input  logic                             rx_orst,

    // cpu side
    input  kiwi_pkg::cpu_op_e                op,
    input  logic [kiwi_pkg::REG_NO_BITS-1:0] reg_no,
    input  logic [kiwi_pkg::TOS_BITS-1:0]    tos,
    input  logic                             rd_reg,
    input  logic                             wr_reg,
    input  logic                             wr_evt,
    output logic [kiwi_pkg::PAR_BITS-1:0]    par,
    output logic                             ser_srq,

    // host and receiver status
    input  logic                             host_srq,
    input  logic                             rx_ovfl,

    // attenuator dac
    output logic                             da_dale,
    output logic                             da_daclk,
    output logic                             da_dadat,

    // gps front end
    output logic                             gps_gscs,
    output logic                             gps_gsclk,
    output logic                             gps_gsdat,

    // board control
    output logic                             adc_clken,
    output logic                             adc_stenl,
    output logic                             ewp,
    output logic                             cmd_ready,
    output logic                             snd_intr
);
    import kiwi_pkg::*;

    logic                id_read;
    logic                id_clk;
    logic                id_shift;
    logic                id_bit;
    logic [CTR_BITS-1:0] ctr0;
    logic [CTR_BITS-1:0] ctr1;

    ////////////////////////////////////////
    // cpu bus
    ////////////////////////////////////////

    cpu_bus_if bus ();

    assign bus.op     = op;
    assign bus.reg_no = reg_no;
    assign bus.tos    = tos;
    assign bus.rd_reg = rd_reg;
    assign bus.wr_reg = wr_reg;
    assign bus.wr_evt = wr_evt;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    ctrl_regs u_ctrl_regs (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .bus       (bus.ctrl_sink),
        .id_read   (id_read),
        .id_clk    (id_clk),
        .id_shift  (id_shift),
        .da_dale   (da_dale),
        .da_daclk  (da_daclk),
        .da_dadat  (da_dadat),
        .gps_gscs  (gps_gscs),
        .gps_gsclk (gps_gsclk),
        .gps_gsdat (gps_gsdat),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    // stands in for the vendor dna primitive
    chip_id_reader #(
        .CHIP_ID (CHIP_ID)
    ) u_chip_id_reader (
        .cpu_clk  (cpu_clk),
        .rx_orst  (rx_orst),
        .id_read  (id_read),
        .id_clk   (id_clk),
        .id_shift (id_shift),
        .id_bit   (id_bit)
    );

    cycle_counters u_cycle_counters (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .bus     (bus.evt_sink),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    cpu_readback #(
        .FPGA_ID (FPGA_ID)
    ) u_cpu_readback (
        .cpu_clk  (cpu_clk),
        .rx_orst  (rx_orst),
        .bus      (bus.rd_sink),
        .host_srq (host_srq),
        .rx_ovfl  (rx_ovfl),
        .id_bit   (id_bit),
        .ctr0     (ctr0),
        .ctr1     (ctr1),
        .par      (par),
        .ser_srq  (ser_srq)
    );

endmodule

// File: source/kiwi_pkg.sv
package kiwi_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int OP_BITS      = 4;    // cpu op code
    localparam int CTRL_BITS    = 16;   // control register
    localparam int PAR_BITS     = 16;   // cpu parallel input
    localparam int TOS_BITS     = 32;   // operand (top of stack)
    localparam int CTR_BITS     = 32;   // each cycle counter
    localparam int REG_NO_BITS  = 2;    // register select
    localparam int ID_BITS      = 57;   // chip id length
    localparam int SER_SEL_BITS = 2;    // serial port select field

    ////////////////////////////////////////
    // control register bit positions
    ////////////////////////////////////////

    localparam int CTRL_SER_SEL    = 0;     // lsb of ser_sel, two bits
    localparam int CTRL_SER_LE_CSN = 2;     // latch / chip select
    localparam int CTRL_SER_CLK    = 3;
    localparam int CTRL_SER_DATA   = 4;
    localparam int CTRL_OSC_DIS    = 5;     // adc osc off when set
    localparam int CTRL_STEN       = 6;     // adc self test
    localparam int CTRL_EEPROM_WP  = 7;
    localparam int CTRL_CMD_READY  = 8;
    localparam int CTRL_SND_INTR   = 9;
    // 15:10 reserved

    // ops decoded by this core
    typedef enum logic [OP_BITS-1:0] {
        OP_NOP,
        OP_SET_CTRL,
        OP_GET_STATUS,
        OP_GET_CPU_CTR,
        OP_GET_SRQ,
        OP_CTR_CLR,
        OP_CTR_ENA,
        OP_CTR_DIS
    } cpu_op_e;

    // which bit-banged port sees the serial bits
    typedef enum logic [SER_SEL_BITS-1:0] {
        SER_NONE,
        SER_ATTN,   // attenuator dac
        SER_GPS,    // gps front end
        SER_ID      // chip id reader
    } ser_sel_e;

endpackage

// File: verification/kiwi_ctrl_core_assert.sv
`timescale 1ns/100ps

module kiwi_ctrl_core_assert (
    input logic                          cpu_clk,
    input logic                          rx_orst,
    input logic [2:0]                    da_pins,      // {le, clk, data}
    input logic [2:0]                    gps_pins,
    input logic [2:0]                    id_pins,
    input logic [4:0]                    board_pins,   // clken, stenl, ewp, cmd, intr
    input logic [kiwi_pkg::CTR_BITS-1:0] ctr0,
    input logic [kiwi_pkg::CTR_BITS-1:0] ctr1
);

    ////////////////////////////////////////
    // serial steering
    ////////////////////////////////////////

    a_one_port: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        $onehot0({|da_pins, |gps_pins, |id_pins}))
        else $error("serial pins active on more than one port");

    // gated counter can never pass the free one
    a_ctr_order: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        ctr1 <= ctr0)
        else $error("ctr1 ahead of ctr0");

    // osc on, self test off, everything else low
    a_reset_pins: assert property (@(posedge cpu_clk)
        rx_orst |=> (board_pins == 5'b11000 && !(|{da_pins, gps_pins, id_pins})))
        else $error("control pins not at reset values after reset");

endmodule

// signals of ctrl_regs and cycle_counters as seen from the top level
bind kiwi_ctrl_core kiwi_ctrl_core_assert u_core_assert (
    .cpu_clk    (cpu_clk),
    .rx_orst    (rx_orst),
    .da_pins    ({da_dale, da_daclk, da_dadat}),
    .gps_pins   ({gps_gscs, gps_gsclk, gps_gsdat}),
    .id_pins    ({id_read, id_clk, id_shift}),
    .board_pins ({adc_clken, adc_stenl, ewp, cmd_ready, snd_intr}),
    .ctr0       (ctr0),
    .ctr1       (ctr1)
);

// File: verification/tb_kiwi_ctrl_core.sv
`timescale 1ns/100ps

module tb_kiwi_ctrl_core;
    import kiwi_pkg::*;

    localparam logic [ID_BITS-1:0] CHIP_ID_TB = 57'h0_3c5a_9e07_d2b6_4f;
    localparam logic [2:0]         FPGA_ID_TB = 3'd5;
    localparam int                 ID_WAIT    = 8;      // cycles allowed per id bit

    // control words for bit-banging the id port
    localparam logic [31:0] W_ID   = 32'(SER_ID);
    localparam logic [31:0] W_LE   = 32'd1 << CTRL_SER_LE_CSN;
    localparam logic [31:0] W_CLK  = 32'd1 << CTRL_SER_CLK;
    localparam logic [31:0] W_DATA = 32'd1 << CTRL_SER_DATA;

    logic                   cpu_clk = 1'b0;
    logic                   rx_orst;
    cpu_op_e                op;
    logic [REG_NO_BITS-1:0] reg_no;
    logic [TOS_BITS-1:0]    tos;
    logic                   rd_reg;
    logic                   wr_reg;
    logic                   wr_evt;
    logic                   host_srq;
    logic                   rx_ovfl;
    logic [PAR_BITS-1:0]    par;
    logic                   ser_srq;
    logic                   da_dale, da_daclk, da_dadat;
    logic                   gps_gscs, gps_gsclk, gps_gsdat;
    logic                   adc_clken, adc_stenl, ewp, cmd_ready, snd_intr;
    logic [10:0]            pins_dut;

    // reference model state
    logic [CTRL_BITS-1:0]   ctrl_m;
    logic [CTR_BITS-1:0]    ctr0_m;
    logic [CTR_BITS-1:0]    ctr1_m;
    logic                   ena_m;
    logic                   ovfl_m;
    logic                   srq_m;          // noted request
    logic                   ser_srq_m;
    int                     id_shifts = -1; // -1 until loaded

    logic [31:0]            lfsr = 32'h571c_4fad;
    int                     chk_cnt = 0;
    int                     err_cnt = 0;
    int                     tmo_cnt = 0;
    int                     chk_start;
    int                     err_start;

    always #5 cpu_clk = !cpu_clk;   // 10 ns

    kiwi_ctrl_core #(
        .CHIP_ID (CHIP_ID_TB),
        .FPGA_ID (FPGA_ID_TB)
    ) dut (.*);

    assign pins_dut = {da_dale, da_daclk, da_dadat, gps_gscs, gps_gsclk, gps_gsdat,
                       adc_clken, adc_stenl, ewp, cmd_ready, snd_intr};

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    always @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            ctrl_m    <= '0;
            ctr0_m    <= '0;
            ctr1_m    <= '0;
            ena_m     <= 1'b0;
            ovfl_m    <= 1'b0;
            srq_m     <= 1'b0;
            ser_srq_m <= 1'b0;
        end
        else
        begin
            if (wr_reg && op == OP_SET_CTRL)
                ctrl_m <= tos[CTRL_BITS-1:0];
            if (wr_evt && op == OP_CTR_CLR)
            begin
                ctr0_m <= '0;
                ctr1_m <= '0;
            end
            else
            begin
                ctr0_m <= ctr0_m + 32'd1;
                ctr1_m <= ena_m ? ctr1_m + 32'd1 : ctr1_m;  // old enable counts
            end
            if (wr_evt && op == OP_CTR_ENA)
                ena_m <= 1'b1;
            else if (wr_evt && op == OP_CTR_DIS)
                ena_m <= 1'b0;
            ovfl_m <= ovfl_m | rx_ovfl;
            if (rd_reg && op == OP_GET_SRQ)
            begin
                ser_srq_m <= srq_m;
                srq_m     <= host_srq;      // note restarts from this cycle
            end
            else
                srq_m <= srq_m | host_srq;
        end
    end

    // pin decode of a control word, dac then gps then board pins
    function automatic logic [10:0] pins_model(input logic [CTRL_BITS-1:0] c);
        logic [2:0] ser;
        logic [1:0] sel;
        ser = {c[CTRL_SER_LE_CSN], c[CTRL_SER_CLK], c[CTRL_SER_DATA]};
        sel = c[1:0];
        return {((sel == SER_ATTN) ? ser : 3'b000), ((sel == SER_GPS) ? ser : 3'b000),
                !c[CTRL_OSC_DIS], !c[CTRL_STEN], c[CTRL_EEPROM_WP],
                c[CTRL_CMD_READY], c[CTRL_SND_INTR]};
    endfunction

    function automatic logic id_model_bit();
        if (id_shifts < 0 || id_shifts >= ID_BITS)
            return 1'b1;                // idle or drained
        return CHIP_ID_TB[ID_BITS-1-id_shifts];     // msb first
    endfunction

    function automatic logic [PAR_BITS-1:0] status_model();
        return {ovfl_m, id_model_bit(), FPGA_ID_TB, 11'd0};
    endfunction

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
        return v;
    endfunction

    // one bus cycle, all strobes driven every time
    task automatic bus_cycle(input cpu_op_e o, input logic [1:0] r, input logic [31:0] t,
                             input logic rd, input logic wr, input logic evt);
        @(posedge cpu_clk);
        op     <= o;
        reg_no <= r;
        tos    <= t;
        rd_reg <= rd;
        wr_reg <= wr;
        wr_evt <= evt;
    endtask

    task automatic idle_cycle();
        bus_cycle(OP_NOP, 2'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic write_ctrl(input logic [31:0] v);
        bus_cycle(OP_SET_CTRL, 2'd0, v, 1'b0, 1'b1, 1'b0);
        idle_cycle();                   // register holds v from here
    endtask

    task automatic reset_dut();
        @(posedge cpu_clk);
        rx_orst <= 1'b1;
        repeat (2) @(posedge cpu_clk);
        rx_orst <= 1'b0;
        id_shifts = -1;
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("** Error @ %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input string what);
        bus_cycle(OP_GET_STATUS, 2'd0, 32'd0, 1'b1, 1'b0, 1'b0);
        @(negedge cpu_clk);
        check_val(what, 32'(par), 32'(status_model()));
    endtask

    // poll the status word until the id bit shows up
    task automatic wait_id_bit(input string what);
        logic exp;
        logic seen;
        exp  = id_model_bit();
        seen = 1'b0;
        for (int w = 0; w < ID_WAIT && !seen; w++)
        begin
            bus_cycle(OP_GET_STATUS, 2'd0, 32'd0, 1'b1, 1'b0, 1'b0);
            @(negedge cpu_clk);
            if (par[14] === exp)
                seen = 1'b1;
        end
        chk_cnt++;
        if (!seen)
        begin
            err_cnt++;
            tmo_cnt++;
            $display("timeout at %0t ns: %s, id bit never read %b after shift %0d",
                     $time, what, exp, id_shifts);
        end
    endtask

    task automatic start_test();
        chk_start = chk_cnt;
        err_start = err_cnt;
    endtask

    task automatic finish_test(input string name);
        $display("%-14s %4d checks, %0d errors", name, chk_cnt - chk_start,
                 err_cnt - err_start);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_after_reset();
        start_test();
        bus_cycle(OP_NOP, 2'd0, 32'd0, 1'b1, 1'b0, 1'b0);   // nop read
        @(negedge cpu_clk);
        check_val("reset pins", 32'(pins_dut), 32'(11'b000_000_11_000));
        check_val("par on nop read", 32'(par), 32'd0);
        check_val("ser_srq after reset", 32'(ser_srq), 32'd0);
        check_status("status after reset");
        finish_test("after_reset");
    endtask

    task automatic test_ctrl_writes();
        start_test();
        for (int n = 0; n < 40; n++)
        begin
            write_ctrl(rand_bits(32));  // random ser_sel too
            @(negedge cpu_clk);
            check_val("ctrl pins", 32'(pins_dut), 32'(pins_model(ctrl_m)));
        end
        write_ctrl(32'd0);
        finish_test("ctrl_writes");
    endtask

    task automatic test_chip_id();
        start_test();
        write_ctrl(W_ID | W_LE);
        write_ctrl(W_ID | W_LE | W_CLK);    // latch with clock loads the id
        write_ctrl(W_ID);
        id_shifts = 0;
        wait_id_bit("id load");
        for (int s = 1; s <= ID_BITS + 1; s++)  // one past drained
        begin
            write_ctrl(W_ID | W_DATA | W_CLK);
            write_ctrl(W_ID | W_DATA);
            id_shifts = s;
            wait_id_bit("id shift");
        end
        write_ctrl(32'd0);
        finish_test("chip_id");
    endtask

    task automatic test_counters();
        logic [2:0] r;
        start_test();
        bus_cycle(OP_CTR_CLR, 2'd0, 32'd0, 1'b0, 1'b0, 1'b1);
        for (int len = 40; len <= 340; len += 300)  // short run, then past byte 0
        begin
            for (int c = 0; c < len; c++)
            begin
                r = 3'(rand_bits(3));
                if (r < 3'd2)
                    bus_cycle(OP_CTR_ENA, 2'd0, 32'd0, 1'b0, 1'b0, 1'b1);
                else if (r == 3'd2)
                    bus_cycle(OP_CTR_DIS, 2'd0, 32'd0, 1'b0, 1'b0, 1'b1);
                else
                    idle_cycle();
            end
            for (int k = 0; k < 4; k++)
            begin
                bus_cycle(OP_GET_CPU_CTR, 2'(k), 32'd0, 1'b1, 1'b0, 1'b0);
                @(negedge cpu_clk);
                check_val("ctr bytes", 32'(par), 32'({ctr1_m[8*k +: 8], ctr0_m[8*k +: 8]}));
            end
        end
        finish_test("counters");
    endtask

    task automatic test_srq_ovfl();
        start_test();
        for (int n = 0; n < 60; n++)
        begin
            bus_cycle(OP_GET_SRQ, 2'd0, 32'd0, rand_bits(2) == 32'd0, 1'b0, 1'b0);
            host_srq <= (rand_bits(2) == 32'd3);    // sparse requests
            @(negedge cpu_clk);
            check_val("ser_srq", 32'(ser_srq), 32'(ser_srq_m));
        end
        idle_cycle();
        host_srq <= 1'b0;
        check_status("status before ovfl");
        idle_cycle();
        rx_ovfl <= 1'b1;                // single pulse
        idle_cycle();
        rx_ovfl <= 1'b0;
        repeat (5)
        begin
            check_status("status after ovfl");
            check_val("ovfl sticky", 32'(par[15]), 32'd1);
        end
        reset_dut();
        check_status("status after reset");
        finish_test("srq_ovfl");
    endtask

    initial
    begin
        rx_orst  = 1'b1;
        op       = OP_NOP;
        reg_no   = '0;
        tos      = '0;
        rd_reg   = 1'b0;
        wr_reg   = 1'b0;
        wr_evt   = 1'b0;
        host_srq = 1'b0;
        rx_ovfl  = 1'b0;
        repeat (2) @(posedge cpu_clk);
        rx_orst <= 1'b0;

        test_after_reset();
        test_ctrl_writes();
        test_chip_id();
        test_counters();
        test_srq_ovfl();

        $display("total: %0d checks, %0d errors, %0d timeouts", chk_cnt, err_cnt, tmo_cnt);
        if (err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
